// ==== axi_chan_pkg.sv ====
// write-channel field types shared by the demultiplexer and its testbench
package axi_chan_pkg;

  // ------------------------------------------------------------------------
  // field widths
  // ------------------------------------------------------------------------
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned LEN_WIDTH  = 8;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned RESP_WIDTH = 2;

  // one strobe bit per data byte
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // ------------------------------------------------------------------------
  // field types
  // ------------------------------------------------------------------------
  // transaction id whose low bits drive the ordering lookups
  typedef logic [ID_WIDTH-1:0]   id_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // burst length minus one
  typedef logic [LEN_WIDTH-1:0]  len_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  // okay, exokay, slverr, decerr
  typedef logic [RESP_WIDTH-1:0] resp_t;

endpackage

// ==== demux_pkg.sv ====
// port-select, capacity and state definitions for the write demultiplexer
package demux_pkg;

  // ------------------------------------------------------------------------
  // master port range
  // ------------------------------------------------------------------------
  // upper bound on master ports that also sizes the select type
  localparam int unsigned MAX_MST_PORTS = 4;

  // bits needed to number every master port
  localparam int unsigned SEL_WIDTH = $clog2(MAX_MST_PORTS);

  // master port number and entry type of the w route queue
  typedef logic [SEL_WIDTH-1:0] mst_sel_t;

  // ------------------------------------------------------------------------
  // aw dispatcher states
  // ------------------------------------------------------------------------
  // AW_IDLE    free to admit a new address when lookup and space allow
  // AW_LOCKED  an address was offered and pushed but not yet accepted
  //            so its valid is held without re-checking the lookup
  typedef enum logic {
    AW_IDLE   = 1'b0,
    AW_LOCKED = 1'b1
  } aw_state_e;

endpackage

// ==== id_counter_table.sv ====
// per-id outstanding write counters with the remembered target port of each id
`timescale 1ns/10ps

module id_counter_table
  import axi_chan_pkg::*;
  import demux_pkg::*;
#(
  parameter int unsigned MaxTrans = 8,
  parameter int unsigned LookBits = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  // lookup for the address waiting at the slave port
  input  id_t      lookup_id_i,
  output mst_sel_t lookup_sel_o,
  output logic     lookup_occupied_o,
  // one more write in flight
  input  logic     push_i,
  input  id_t      push_id_i,
  input  mst_sel_t push_sel_i,
  // a write response left on the slave side
  input  logic     pop_i,
  input  id_t      pop_id_i,
  output logic     full_o
);

  localparam int unsigned NumCnt   = 2 ** LookBits;
  localparam int unsigned CntWidth = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;

  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t                cnt_q [NumCnt];
  mst_sel_t            sel_q [NumCnt];
  logic [LookBits-1:0] lookup_idx;
  logic [LookBits-1:0] push_idx;
  logic [LookBits-1:0] pop_idx;
  logic [NumCnt-1:0]   push_en;
  logic [NumCnt-1:0]   pop_en;
  logic [NumCnt-1:0]   at_max;

  // only the low id bits select a counter
  assign lookup_idx = lookup_id_i[LookBits-1:0];
  assign push_idx   = push_id_i[LookBits-1:0];
  assign pop_idx    = pop_id_i[LookBits-1:0];

  // ------------------------------------------------------------------------
  // decode and full detection
  // ------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NumCnt; i++) begin
      push_en[i] = push_i && (push_idx == LookBits'(i));
      pop_en[i]  = pop_i && (pop_idx == LookBits'(i));
      // a saturated counter could not take another push
      at_max[i]  = &cnt_q[i];
    end
  end

  assign full_o            = |at_max;
  assign lookup_occupied_o = |cnt_q[lookup_idx];
  assign lookup_sel_o      = sel_q[lookup_idx];

  // ------------------------------------------------------------------------
  // up/down counters
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NumCnt; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumCnt; i++) begin
        // push and pop together on one id cancel out
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
      end
    end
  end

  // port of the last push is only read while the counter is non-zero
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumCnt; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

endmodule

// ==== aw_dispatch.sv ====
// write address dispatcher that admits, steers and locks aw requests
`timescale 1ns/10ps

module aw_dispatch
  import axi_chan_pkg::*;
  import demux_pkg::*;
#(
  parameter int unsigned NumMstPorts = 3
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // slave side address request
  input  logic                   slv_aw_valid_i,
  input  id_t                    slv_aw_id_i,
  input  mst_sel_t               slv_aw_select_i,
  output logic                   slv_aw_ready_o,
  // master side handshake
  output logic [NumMstPorts-1:0] mst_aw_valid_o,
  input  logic [NumMstPorts-1:0] mst_aw_ready_i,
  // counter table and w queue status
  output id_t                    lookup_id_o,
  input  mst_sel_t               lookup_sel_i,
  input  logic                   lookup_occupied_i,
  input  logic                   cnt_full_i,
  input  logic                   fifo_full_i,
  output logic                   push_o
);

  aw_state_e state_q;
  aw_state_e state_d;
  logic      aw_valid;
  logic      port_ready;
  logic      admit;

  assign lookup_id_o = slv_aw_id_i;

  // id is free or already heading to the same port
  assign admit = slv_aw_valid_i && !cnt_full_i && !fifo_full_i &&
                 (!lookup_occupied_i || (lookup_sel_i == slv_aw_select_i));

  // ------------------------------------------------------------------------
  // steering of the single valid and the matching ready
  // ------------------------------------------------------------------------
  always_comb begin
    mst_aw_valid_o = '0;
    port_ready     = 1'b0;
    for (int p = 0; p < NumMstPorts; p++) begin
      if (slv_aw_select_i == mst_sel_t'(p)) begin
        mst_aw_valid_o[p] = aw_valid;
        port_ready        = mst_aw_ready_i[p];
      end
    end
  end

  // ------------------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    aw_valid       = 1'b0;
    push_o         = 1'b0;
    slv_aw_ready_o = 1'b0;
    unique case (state_q)
      AW_IDLE: begin
        if (admit) begin
          aw_valid       = 1'b1;
          // route decision goes to the w queue at first offer
          push_o         = 1'b1;
          slv_aw_ready_o = port_ready;
          if (!port_ready) begin
            state_d = AW_LOCKED;
          end
        end
      end
      AW_LOCKED: begin
        // hold the offer without looking at lookup and full flags
        aw_valid       = 1'b1;
        slv_aw_ready_o = port_ready;
        if (port_ready) begin
          state_d = AW_IDLE;
        end
      end
      default: state_d = AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== w_route_fifo.sv ====
// queue of aw port decisions that steers write data bursts to their master
`timescale 1ns/10ps

module w_route_fifo
  import demux_pkg::*;
#(
  parameter int unsigned NumMstPorts = 3,
  parameter int unsigned MaxTrans    = 8
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // decisions from the aw dispatcher
  input  logic                   push_i,
  input  mst_sel_t               push_sel_i,
  output logic                   full_o,
  // slave side w handshake
  input  logic                   slv_w_valid_i,
  input  logic                   slv_w_last_i,
  output logic                   slv_w_ready_o,
  // master side w handshake
  output logic [NumMstPorts-1:0] mst_w_valid_o,
  input  logic [NumMstPorts-1:0] mst_w_ready_i
);

  localparam int unsigned PtrWidth = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   fill_t;

  mst_sel_t mem_q [MaxTrans];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  fill_t    fill_q;
  logic     empty;
  logic     push_ok;
  logic     pop;
  mst_sel_t head_sel;

  assign full_o   = (fill_q == fill_t'(MaxTrans));
  assign empty    = (fill_q == '0);
  assign push_ok  = push_i && !full_o;
  assign head_sel = mem_q[rd_ptr_q];

  // ------------------------------------------------------------------------
  // w steering once a decision sits at the head
  // ------------------------------------------------------------------------
  always_comb begin
    mst_w_valid_o = '0;
    slv_w_ready_o = 1'b0;
    for (int p = 0; p < NumMstPorts; p++) begin
      if (!empty && (head_sel == mst_sel_t'(p))) begin
        mst_w_valid_o[p] = slv_w_valid_i;
        slv_w_ready_o    = mst_w_ready_i[p];
      end
    end
  end

  // last beat of the burst retires the decision
  assign pop = slv_w_valid_i && slv_w_ready_o && slv_w_last_i;

  // ------------------------------------------------------------------------
  // pointers and fill level
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(MaxTrans - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(MaxTrans - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      if (push_ok && !pop) begin
        fill_q <= fill_q + fill_t'(1);
      end else if (pop && !push_ok) begin
        fill_q <= fill_q - fill_t'(1);
      end
    end
  end

  // storage is valid only between read and write pointer
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_sel_i;
    end
  end

endmodule

// ==== b_arbiter.sv ====
// round-robin merge of master write responses onto the slave port with lock-in
`timescale 1ns/10ps

module b_arbiter
  import axi_chan_pkg::*;
  import demux_pkg::*;
#(
  parameter int unsigned NumMstPorts = 3
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // master side responses
  input  logic [NumMstPorts-1:0] mst_b_valid_i,
  input  id_t  [NumMstPorts-1:0] mst_b_id_i,
  input  resp_t [NumMstPorts-1:0] mst_b_resp_i,
  output logic [NumMstPorts-1:0] mst_b_ready_o,
  // merged slave side response
  output logic                   slv_b_valid_o,
  output id_t                    slv_b_id_o,
  output resp_t                  slv_b_resp_o,
  input  logic                   slv_b_ready_i,
  // retire one write in the counter table
  output logic                   pop_o,
  output id_t                    pop_id_o
);

  mst_sel_t rr_q;
  mst_sel_t grant_q;
  logic     locked_q;
  mst_sel_t pick;
  mst_sel_t grant;
  logic     found;

  // first valid requester at or after the pointer
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = rr_q;
    idx   = 0;
    for (int k = 0; k < NumMstPorts; k++) begin
      idx = (int'(rr_q) + k) % NumMstPorts;
      if (!found && mst_b_valid_i[idx]) begin
        found = 1'b1;
        pick  = mst_sel_t'(idx);
      end
    end
  end

  // a stalled grant stays with its port
  assign grant         = locked_q ? grant_q : pick;
  assign slv_b_valid_o = locked_q ? mst_b_valid_i[grant_q] : found;
  assign slv_b_id_o    = mst_b_id_i[grant];
  assign slv_b_resp_o  = mst_b_resp_i[grant];
  assign pop_o         = slv_b_valid_o && slv_b_ready_i;
  assign pop_id_o      = slv_b_id_o;

  always_comb begin
    for (int p = 0; p < NumMstPorts; p++) begin
      mst_b_ready_o[p] = pop_o && (grant == mst_sel_t'(p));
    end
  end

  // ------------------------------------------------------------------------
  // lock and pointer update
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q     <= '0;
      grant_q  <= '0;
      locked_q <= 1'b0;
    end else begin
      locked_q <= slv_b_valid_o && !slv_b_ready_i;
      if (slv_b_valid_o && !slv_b_ready_i) begin
        grant_q <= grant;
      end
      // move past the winner so every port gets its turn
      if (pop_o) begin
        rr_q <= (grant == mst_sel_t'(NumMstPorts - 1)) ? '0 : grant + mst_sel_t'(1);
      end
    end
  end

endmodule

// ==== write_demux_top.sv ====
// write-only bus demultiplexer from one slave port to several master ports
`timescale 1ns/10ps

module write_demux_top
  import axi_chan_pkg::*;
  import demux_pkg::*;
#(
  parameter int unsigned NumMstPorts = 3,
  parameter int unsigned MaxTrans    = 8,
  parameter int unsigned LookBits    = 2
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // slave port
  input  logic                    slv_aw_valid_i,
  input  id_t                     slv_aw_id_i,
  input  addr_t                   slv_aw_addr_i,
  input  len_t                    slv_aw_len_i,
  input  mst_sel_t                slv_aw_select_i,
  output logic                    slv_aw_ready_o,
  input  logic                    slv_w_valid_i,
  input  data_t                   slv_w_data_i,
  input  strb_t                   slv_w_strb_i,
  input  logic                    slv_w_last_i,
  output logic                    slv_w_ready_o,
  output logic                    slv_b_valid_o,
  output id_t                     slv_b_id_o,
  output resp_t                   slv_b_resp_o,
  input  logic                    slv_b_ready_i,
  // master ports
  output logic  [NumMstPorts-1:0] mst_aw_valid_o,
  output id_t   [NumMstPorts-1:0] mst_aw_id_o,
  output addr_t [NumMstPorts-1:0] mst_aw_addr_o,
  output len_t  [NumMstPorts-1:0] mst_aw_len_o,
  input  logic  [NumMstPorts-1:0] mst_aw_ready_i,
  output logic  [NumMstPorts-1:0] mst_w_valid_o,
  output data_t [NumMstPorts-1:0] mst_w_data_o,
  output strb_t [NumMstPorts-1:0] mst_w_strb_o,
  output logic  [NumMstPorts-1:0] mst_w_last_o,
  input  logic  [NumMstPorts-1:0] mst_w_ready_i,
  input  logic  [NumMstPorts-1:0] mst_b_valid_i,
  input  id_t   [NumMstPorts-1:0] mst_b_id_i,
  input  resp_t [NumMstPorts-1:0] mst_b_resp_i,
  output logic  [NumMstPorts-1:0] mst_b_ready_o
);

  if (NumMstPorts < 2 || NumMstPorts > MAX_MST_PORTS) begin : gen_bad_ports
    $error("NumMstPorts must be between 2 and %0d", MAX_MST_PORTS);
  end

  id_t      lookup_id;
  mst_sel_t lookup_sel;
  logic     lookup_occupied;
  logic     cnt_full;
  logic     fifo_full;
  logic     push;
  logic     pop;
  id_t      pop_id;

  // ------------------------------------------------------------------------
  // payload fields go to every port while only the valids are steered
  // ------------------------------------------------------------------------
  assign mst_aw_id_o   = {NumMstPorts{slv_aw_id_i}};
  assign mst_aw_addr_o = {NumMstPorts{slv_aw_addr_i}};
  assign mst_aw_len_o  = {NumMstPorts{slv_aw_len_i}};
  assign mst_w_data_o  = {NumMstPorts{slv_w_data_i}};
  assign mst_w_strb_o  = {NumMstPorts{slv_w_strb_i}};
  assign mst_w_last_o  = {NumMstPorts{slv_w_last_i}};

  aw_dispatch #(.NumMstPorts(NumMstPorts)) u_aw_dispatch (
    .clk_i, .reset_i, .slv_aw_valid_i, .slv_aw_id_i, .slv_aw_select_i, .slv_aw_ready_o,
    .mst_aw_valid_o, .mst_aw_ready_i,
    .lookup_id_o       (lookup_id),
    .lookup_sel_i      (lookup_sel),
    .lookup_occupied_i (lookup_occupied),
    .cnt_full_i        (cnt_full),
    .fifo_full_i       (fifo_full),
    .push_o            (push)
  );

  // push carries the admitted address id and its port
  id_counter_table #(.MaxTrans(MaxTrans), .LookBits(LookBits)) u_id_counter_table (
    .clk_i, .reset_i,
    .lookup_id_i (lookup_id), .lookup_sel_o (lookup_sel),
    .lookup_occupied_o (lookup_occupied),
    .push_i (push), .push_id_i (lookup_id), .push_sel_i (slv_aw_select_i),
    .pop_i (pop), .pop_id_i (pop_id), .full_o (cnt_full)
  );

  w_route_fifo #(.NumMstPorts(NumMstPorts), .MaxTrans(MaxTrans)) u_w_route_fifo (
    .clk_i, .reset_i, .push_i (push), .push_sel_i (slv_aw_select_i), .full_o (fifo_full),
    .slv_w_valid_i, .slv_w_last_i, .slv_w_ready_o, .mst_w_valid_o, .mst_w_ready_i
  );

  b_arbiter #(.NumMstPorts(NumMstPorts)) u_b_arbiter (
    .clk_i, .reset_i, .mst_b_valid_i, .mst_b_id_i, .mst_b_resp_i, .mst_b_ready_o,
    .slv_b_valid_o, .slv_b_id_o, .slv_b_resp_o, .slv_b_ready_i,
    .pop_o (pop), .pop_id_o (pop_id)
  );

endmodule

// ==== write_demux_assertions.sv ====
// concurrent checks on the aw dispatcher handshake, request fields and port select
`timescale 1ns/10ps

module write_demux_assertions
  import axi_chan_pkg::*;
  import demux_pkg::*;
#(
  parameter int unsigned NumMstPorts = 3
) (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   slv_aw_valid_i,
  input id_t                    slv_aw_id_i,
  input mst_sel_t               slv_aw_select_i,
  input logic                   slv_aw_ready_o,
  input logic [NumMstPorts-1:0] mst_aw_valid_o,
  input logic [NumMstPorts-1:0] mst_aw_ready_i
);

  // ------------------------------------------------------------------------
  // offer locking
  // ------------------------------------------------------------------------
  // an offer not taken stays on the same port next cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    ((|mst_aw_valid_o) && !slv_aw_ready_o) |=> (mst_aw_valid_o == $past(mst_aw_valid_o)))
    else $error("aw valid dropped or moved to another port before ready");

  // ------------------------------------------------------------------------
  // request fields and select
  // ------------------------------------------------------------------------
  // waiting requester keeps id and select
  assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_aw_valid_i && !slv_aw_ready_o) |=> ($stable(slv_aw_id_i) && $stable(slv_aw_select_i)))
    else $error("aw id or select changed while waiting for ready");

  // requester select must name an existing port
  assert property (@(posedge clk_i) disable iff (reset_i)
    slv_aw_valid_i |-> (int'(slv_aw_select_i) < NumMstPorts))
    else $error("aw select out of range");

endmodule

// ==== tb_write_demux.sv ====
// random-stimulus testbench for the write demultiplexer with master responders and model
`timescale 1ns/10ps

module tb_write_demux
  import axi_chan_pkg::*;
  import demux_pkg::*;
();

  localparam int NPORTS       = 3;
  localparam int MAX_TRANS    = 8;
  localparam int LOOK_BITS    = 2;
  localparam int NUM_WRITES   = 200;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  // budget of 40 cycles per write
  localparam int WATCHDOG_NS  = NUM_WRITES * 40 * CLK_PERIOD;

  logic                  clk_i;
  logic                  reset_i;
  logic                  slv_aw_valid_i;
  id_t                   slv_aw_id_i;
  addr_t                 slv_aw_addr_i;
  len_t                  slv_aw_len_i;
  mst_sel_t              slv_aw_select_i;
  logic                  slv_aw_ready_o;
  logic                  slv_w_valid_i;
  data_t                 slv_w_data_i;
  strb_t                 slv_w_strb_i;
  logic                  slv_w_last_i;
  logic                  slv_w_ready_o;
  logic                  slv_b_valid_o;
  id_t                   slv_b_id_o;
  resp_t                 slv_b_resp_o;
  logic                  slv_b_ready_i;
  logic  [NPORTS-1:0]    mst_aw_valid_o;
  id_t   [NPORTS-1:0]    mst_aw_id_o;
  addr_t [NPORTS-1:0]    mst_aw_addr_o;
  len_t  [NPORTS-1:0]    mst_aw_len_o;
  logic  [NPORTS-1:0]    mst_aw_ready_i;
  logic  [NPORTS-1:0]    mst_w_valid_o;
  data_t [NPORTS-1:0]    mst_w_data_o;
  strb_t [NPORTS-1:0]    mst_w_strb_o;
  logic  [NPORTS-1:0]    mst_w_last_o;
  logic  [NPORTS-1:0]    mst_w_ready_i;
  logic  [NPORTS-1:0]    mst_b_valid_i;
  id_t   [NPORTS-1:0]    mst_b_id_i;
  resp_t [NPORTS-1:0]    mst_b_resp_i;
  logic  [NPORTS-1:0]    mst_b_ready_o;

  // ------------------------------------------------------------------------
  // model state
  // ------------------------------------------------------------------------
  // generated writes indexed by issue number
  id_t      wr_id   [NUM_WRITES];
  addr_t    wr_addr [NUM_WRITES];
  len_t     wr_len  [NUM_WRITES];
  mst_sel_t wr_sel  [NUM_WRITES];
  int       aw_sent;
  int       w_beat;
  int       inflight;
  int       b_issued;
  int       b_seen;
  logic     running;
  // accepted writes still owing w beats in acceptance order
  int       acc_q [$];
  int       aw_exp [NPORTS][$];
  data_t    wexp_data [NPORTS][$];
  strb_t    wexp_strb [NPORTS][$];
  logic     wexp_last [NPORTS][$];
  // outstanding writes per low id bits and port
  int       out_cnt [2**LOOK_BITS][NPORTS];
  // responder bookkeeping
  id_t      rsp_aw [NPORTS][$];
  int       rsp_wdone [NPORTS];
  id_t      rsp_b [NPORTS][$];
  int       b_wait [NPORTS];

  write_demux_top #(
    .NumMstPorts (NPORTS),
    .MaxTrans    (MAX_TRANS),
    .LookBits    (LOOK_BITS)
  ) u_dut (.*);

  bind aw_dispatch write_demux_assertions #(.NumMstPorts(NumMstPorts)) u_aw_assertions (
    .clk_i, .reset_i, .slv_aw_valid_i, .slv_aw_id_i, .slv_aw_select_i, .slv_aw_ready_o,
    .mst_aw_valid_o, .mst_aw_ready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------------
  // reporting and compare tasks
  // ------------------------------------------------------------------------
  task automatic report_error(string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_aw(int port, id_t got_id, addr_t got_addr, len_t got_len,
                          id_t exp_id, addr_t exp_addr, len_t exp_len);
    if (got_id !== exp_id || got_addr !== exp_addr || got_len !== exp_len) begin
      report_error($sformatf("aw port %0d got id %h addr %h len %0d, expected %h %h %0d",
                             port, got_id, got_addr, got_len, exp_id, exp_addr, exp_len));
    end
  endtask

  task automatic check_w(int port, data_t got_data, strb_t got_strb, logic got_last,
                         data_t exp_data, strb_t exp_strb, logic exp_last);
    if (got_data !== exp_data || got_strb !== exp_strb || got_last !== exp_last) begin
      report_error($sformatf("w port %0d got %h/%h/%b, expected %h/%h/%b", port,
                             got_data, got_strb, got_last, exp_data, exp_strb, exp_last));
    end
  endtask

  task automatic check_b(id_t got_id, resp_t got_resp, id_t exp_id, resp_t exp_resp);
    if (got_id !== exp_id || got_resp !== exp_resp) begin
      report_error($sformatf("b got id %h resp %0d, expected id %h resp %0d",
                             got_id, got_resp, exp_id, exp_resp));
    end
  endtask

  task automatic expect_quiet_outputs();
    if (slv_b_valid_o !== 1'b0 || mst_aw_valid_o !== '0 || mst_w_valid_o !== '0) begin
      report_error("valid output high during or right after reset");
    end
  endtask

  // ------------------------------------------------------------------------
  // per-cycle sampling of values from the cycle that just ended
  // ------------------------------------------------------------------------
  task automatic sample_channels();
    int                   n;
    int                   nb;
    int                   bp;
    logic [LOOK_BITS-1:0] low;
    low = slv_aw_id_i[LOOK_BITS-1:0];
    // ordering rule is checked before this cycle's transfers touch the model
    for (int p = 0; p < NPORTS; p++) begin
      for (int q = 0; q < NPORTS; q++) begin
        if (mst_aw_valid_o[p] && q != p && out_cnt[low][q] != 0) begin
          report_error($sformatf("id %h offered to port %0d while outstanding at port %0d",
                                 slv_aw_id_i, p, q));
        end
      end
    end
    if (slv_aw_valid_i && slv_aw_ready_o) begin
      n = aw_sent - 1;
      aw_exp[wr_sel[n]].push_back(n);
      acc_q.push_back(n);
      out_cnt[low][wr_sel[n]]++;
      inflight++;
      if (inflight > MAX_TRANS) begin
        report_error($sformatf("%0d writes in flight, limit is %0d", inflight, MAX_TRANS));
      end
    end
    for (int p = 0; p < NPORTS; p++) begin
      if (mst_aw_valid_o[p] && mst_aw_ready_i[p]) begin
        if (aw_exp[p].size() == 0) begin
          report_error($sformatf("unexpected address at port %0d", p));
        end
        n = aw_exp[p].pop_front();
        check_aw(p, mst_aw_id_o[p], mst_aw_addr_o[p], mst_aw_len_o[p],
                 wr_id[n], wr_addr[n], wr_len[n]);
        rsp_aw[p].push_back(mst_aw_id_o[p]);
      end
    end
    // w beats go to the port of the oldest accepted write
    if (slv_w_valid_i && slv_w_ready_o) begin
      n = acc_q[0];
      wexp_data[wr_sel[n]].push_back(slv_w_data_i);
      wexp_strb[wr_sel[n]].push_back(slv_w_strb_i);
      wexp_last[wr_sel[n]].push_back(slv_w_last_i);
      if (slv_w_last_i) begin
        acc_q.delete(0);
        inflight--;
      end
    end
    for (int p = 0; p < NPORTS; p++) begin
      if (mst_w_valid_o[p] && mst_w_ready_i[p]) begin
        if (wexp_data[p].size() == 0) begin
          report_error($sformatf("unexpected w beat at port %0d", p));
        end
        check_w(p, mst_w_data_o[p], mst_w_strb_o[p], mst_w_last_o[p],
                wexp_data[p].pop_front(), wexp_strb[p].pop_front(), wexp_last[p].pop_front());
        if (mst_w_last_o[p]) begin
          rsp_wdone[p]++;
        end
      end
    end
    // a slave b transfer takes exactly one master response in the same cycle
    nb = 0;
    bp = 0;
    for (int p = 0; p < NPORTS; p++) begin
      if (mst_b_valid_i[p] && mst_b_ready_o[p]) begin
        nb++;
        bp = p;
      end
    end
    if (slv_b_valid_o && slv_b_ready_i) begin
      if (nb != 1) begin
        report_error($sformatf("slave b transfer took %0d master responses", nb));
      end
      check_b(slv_b_id_o, slv_b_resp_o, mst_b_id_i[bp], mst_b_resp_i[bp]);
      out_cnt[mst_b_id_i[bp][LOOK_BITS-1:0]][bp]--;
      b_seen++;
    end else if (nb != 0) begin
      report_error("master response taken without reaching the slave port");
    end
  endtask

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------
  task automatic drive_slave();
    int n;
    if (slv_aw_valid_i && slv_aw_ready_o) begin
      slv_aw_valid_i <= 1'b0;
    end
    if ((!slv_aw_valid_i || slv_aw_ready_o) && aw_sent < NUM_WRITES && $urandom % 2 == 0) begin
      n          = aw_sent;
      wr_id[n]   = id_t'($urandom);
      wr_sel[n]  = mst_sel_t'($urandom % NPORTS);
      wr_addr[n] = $urandom;
      wr_len[n]  = len_t'($urandom % 4);
      slv_aw_valid_i  <= 1'b1;
      slv_aw_id_i     <= wr_id[n];
      slv_aw_addr_i   <= wr_addr[n];
      slv_aw_len_i    <= wr_len[n];
      slv_aw_select_i <= wr_sel[n];
      aw_sent++;
    end
    if (slv_w_valid_i && slv_w_ready_o) begin
      slv_w_valid_i <= 1'b0;
      w_beat = slv_w_last_i ? 0 : w_beat + 1;
    end
    // random gaps between beats
    if ((!slv_w_valid_i || slv_w_ready_o) && acc_q.size() > 0 && $urandom % 3 != 0) begin
      n = acc_q[0];
      slv_w_valid_i <= 1'b1;
      slv_w_data_i  <= $urandom;
      slv_w_strb_i  <= strb_t'($urandom);
      slv_w_last_i  <= (w_beat == int'(wr_len[n]));
    end
    slv_b_ready_i <= ($urandom % 3) != 0;
  endtask

  // one responder per master port returning b only after both address and last beat
  task automatic drive_responders();
    for (int p = 0; p < NPORTS; p++) begin
      mst_aw_ready_i[p] <= ($urandom % 4) != 0;
      mst_w_ready_i[p]  <= ($urandom % 4) != 0;
      if (rsp_aw[p].size() > 0 && rsp_wdone[p] > 0) begin
        rsp_b[p].push_back(rsp_aw[p].pop_front());
        rsp_wdone[p]--;
      end
      if (mst_b_valid_i[p] && mst_b_ready_o[p]) begin
        mst_b_valid_i[p] <= 1'b0;
        b_wait[p] = $urandom % 5;
      end else if (!mst_b_valid_i[p] && rsp_b[p].size() > 0) begin
        if (b_wait[p] > 0) begin
          b_wait[p]--;
        end else begin
          mst_b_valid_i[p] <= 1'b1;
          mst_b_id_i[p]    <= rsp_b[p].pop_front();
          mst_b_resp_i[p]  <= resp_t'($urandom);
          b_issued++;
        end
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (running) begin
      sample_channels();
      drive_slave();
      drive_responders();
    end
  end

  // ------------------------------------------------------------------------
  // run control
  // ------------------------------------------------------------------------
  initial begin
    int pending;
    void'($urandom(32'h7302));
    running         = 1'b0;
    reset_i         = 1'b1;
    slv_aw_valid_i  = 1'b0;
    slv_aw_id_i     = '0;
    slv_aw_addr_i   = '0;
    slv_aw_len_i    = '0;
    slv_aw_select_i = '0;
    slv_w_valid_i   = 1'b0;
    slv_w_data_i    = '0;
    slv_w_strb_i    = '0;
    slv_w_last_i    = 1'b0;
    slv_b_ready_i   = 1'b0;
    mst_aw_ready_i  = '0;
    mst_w_ready_i   = '0;
    mst_b_valid_i   = '0;
    mst_b_id_i      = '0;
    mst_b_resp_i    = '0;
    aw_sent         = 0;
    w_beat          = 0;
    inflight        = 0;
    b_issued        = 0;
    b_seen          = 0;
    for (int p = 0; p < NPORTS; p++) begin
      rsp_wdone[p] = 0;
      b_wait[p]    = 0;
      for (int i = 0; i < 2**LOOK_BITS; i++) begin
        out_cnt[i][p] = 0;
      end
    end
    // registers are settled after the first reset edge
    @(posedge clk_i);
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk_i);
      expect_quiet_outputs();
    end
    reset_i <= 1'b0;
    @(posedge clk_i);
    expect_quiet_outputs();
    running <= 1'b1;
    wait (b_seen == NUM_WRITES);
    repeat (10) @(posedge clk_i);
    pending = acc_q.size() + (b_issued - b_seen);
    for (int p = 0; p < NPORTS; p++) begin
      pending += aw_exp[p].size() + wexp_data[p].size() + rsp_aw[p].size() + rsp_b[p].size();
    end
    if (pending != 0 || slv_b_valid_o) begin
      report_error($sformatf("%0d items left over after all responses", pending));
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired with %0d of %0d responses returned", b_seen, NUM_WRITES);
    $display("Regression failed");
    $fatal(1, "simulation timed out");
  end

endmodule

// ==== sim.f ====
axi_chan_pkg.sv
demux_pkg.sv
id_counter_table.sv
aw_dispatch.sv
w_route_fifo.sv
b_arbiter.sv
write_demux_top.sv
write_demux_assertions.sv
tb_write_demux.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_write_demux
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
